// File: project.f
+incdir+source
source/mp_noc_pkg.sv
source/mp_bus_pkg.sv
source/mp_fifo_if.sv
source/mp_bus_decode.sv
source/mp_egress_ctrl.sv
source/mp_ingress_ctrl.sv
source/mp_packet_buffer.sv
source/mp_control_responder.sv
source/mp_simple.sv
verif/mp_simple_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the mp_simple testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module mp_simple_tb -o mp_simple_sim

./obj_dir/mp_simple_sim > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
   exit 1
fi
exit 0

// File: source/mp_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mp_settings.svh"

module mp_bus_decode (
   input  wire                 clk,
   input  wire                 rst,
   input  mp_bus_pkg::addr_t   bus_addr,
   input  wire                 bus_we,
   input  wire                 bus_en,
   input  mp_bus_pkg::word_t   bus_data_in,
   input  wire                 noc_out_valid,
   input  wire                 irq,
   output mp_bus_pkg::word_t   bus_data_out,
   output logic                bus_ack,
   output logic                enabled,
   mp_fifo_if.decoder          fifo
);
   import mp_bus_pkg::*;

   reg_idx_t reg_idx;
   logic     ctrl_wr;

   // Word index with the byte offset dropped
   assign reg_idx = bus_addr[`MP_BUS_ADDR_WIDTH-1:2];

   // Egress controller sees the bus data directly
   assign fifo.wr_data = bus_data_in;

   always_comb begin
      bus_ack      = 1'b0;
      bus_data_out = '0;
      fifo.rd_en   = 1'b0;
      fifo.wr_en   = 1'b0;
      ctrl_wr      = 1'b0;
      if (bus_en) begin
         if (reg_idx == `MP_REG_FIFO) begin
            // FIFO register acks come from the controllers
            if (bus_we) begin
               fifo.wr_en = 1'b1;
               bus_ack    = fifo.wr_ack;
            end else begin
               fifo.rd_en   = 1'b1;
               bus_ack      = fifo.rd_ack;
               bus_data_out = fifo.rd_data;
            end
         end else if (reg_idx == `MP_REG_CTRL) begin
            // Control register always acks at once
            bus_ack = 1'b1;
            if (bus_we) begin
               ctrl_wr = 1'b1;
            end else begin
               // Status bit 1 is egress pending and bit 0 ingress pending
               bus_data_out = word_t'({noc_out_valid, irq});
            end
         end
      end
   end

   // Enable is sticky until reset
   always_ff @(posedge clk) begin
      if (rst) begin
         enabled <= 1'b0;
      end else if (ctrl_wr) begin
         enabled <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: source/mp_bus_pkg.sv
`default_nettype none

`include "mp_settings.svh"

package mp_bus_pkg;

   // Byte address as seen on the bus
   typedef logic [`MP_BUS_ADDR_WIDTH-1:0] addr_t;
   // Word index, address bits above the byte offset
   typedef logic [`MP_BUS_ADDR_WIDTH-3:0] reg_idx_t;
   // Bus data word
   typedef logic [`MP_DATA_WIDTH-1:0]     word_t;

endpackage

`default_nettype wire

// File: source/mp_control_responder.sv
`timescale 1ns/1ps
`default_nettype none

`include "mp_settings.svh"

module mp_control_responder (
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 enabled,
   input  mp_noc_pkg::flit_t   noc_in_flit,
   input  wire                 noc_in_valid,
   input  wire                 ing_ready,
   input  mp_noc_pkg::flit_t   egr_flit,
   input  wire                 egr_valid,
   input  wire                 noc_out_ready,
   output logic                noc_in_ready,
   output mp_noc_pkg::flit_t   ing_flit,
   output logic                ing_valid,
   output mp_noc_pkg::flit_t   noc_out_flit,
   output logic                noc_out_valid,
   output logic                egr_ready
);
   import mp_noc_pkg::*;

   logic  is_req;
   logic  capture;
   logic  pending;
   flit_t reply;
   // Egress is in the middle of a packet on the NoC output
   logic  in_pkt;
   logic  egr_first;
   logic  reply_sent;

   // Control request is a single flit of control class with bit 0 clear
   assign is_req = (noc_in_flit[type_lsb +: $bits(flit_type_t)] == flit_single) &&
                   (noc_in_flit[class_lsb +: $bits(class_t)] == `MP_CTRL_CLASS) &&
                   !noc_in_flit[0];

   // Requests are taken without waiting on the ingress buffer
   assign noc_in_ready = !pending & (is_req | ing_ready);
   assign capture      = noc_in_valid & !pending & is_req;
   assign ing_flit     = noc_in_flit;
   assign ing_valid    = noc_in_valid & !pending & !is_req;

   // Header, payload or a last flit still owed keep the output
   assign egr_first  = egr_valid & (in_pkt | !egr_flit[type_end_bit]);
   assign reply_sent = pending & !egr_first & noc_out_ready;

   always_comb begin
      if (egr_first || !pending) begin
         noc_out_flit  = egr_flit;
         noc_out_valid = egr_valid;
         egr_ready     = noc_out_ready;
      end else begin
         noc_out_flit  = reply;
         noc_out_valid = 1'b1;
         egr_ready     = 1'b0;
      end
   end

   // Reply swaps source and destination and reports enable in bit 1
   always_ff @(posedge clk) begin
      if (capture) begin
         reply <= {flit_single,
                   noc_in_flit[src_lsb +: $bits(node_t)],
                   `MP_CTRL_CLASS,
                   noc_in_flit[dest_lsb +: $bits(node_t)],
                   {(src_lsb - 2){1'b0}},
                   enabled,
                   1'b1};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pending <= 1'b0;
         in_pkt  <= 1'b0;
      end else begin
         if (capture) begin
            pending <= 1'b1;
         end else if (reply_sent) begin
            pending <= 1'b0;
         end
         // Open after header or payload and closed after last or single
         if (egr_valid && egr_ready) begin
            in_pkt <= !egr_flit[type_end_bit];
         end
      end
   end

endmodule

`default_nettype wire

// File: source/mp_egress_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mp_egress_ctrl (
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 buf_ready,
   output mp_noc_pkg::flit_t   buf_flit,
   output logic                buf_valid,
   mp_fifo_if.egress           fifo
);
   import mp_noc_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_first,
      st_payload
   } state_t;

   state_t     state;
   state_t     nxt_state;
   // Flits still to be written in this packet
   size_t      remaining;
   size_t      nxt_remaining;
   flit_type_t flit_type;

   // Bus word goes straight into the flit
   assign buf_flit = {flit_type, fifo.wr_data};

   always_comb begin
      nxt_state     = state;
      nxt_remaining = remaining;
      fifo.wr_ack   = 1'b0;
      buf_valid     = 1'b0;
      flit_type     = flit_payload;
      case (state)
         st_idle: begin
            // First write of a packet is its size
            if (fifo.wr_en) begin
               nxt_remaining = fifo.wr_data[$bits(size_t)-1:0];
               fifo.wr_ack   = 1'b1;
               nxt_state     = st_first;
            end
         end
         st_first, st_payload: begin
            if (fifo.wr_en) begin
               buf_valid = 1'b1;
               // Type depends on position in packet
               if (state == st_first) begin
                  flit_type = (remaining == 1) ? flit_single : flit_header;
               end else begin
                  flit_type = (remaining == 1) ? flit_last : flit_payload;
               end
               // Bus held until the buffer takes the flit
               if (buf_ready) begin
                  fifo.wr_ack   = 1'b1;
                  nxt_remaining = remaining - 1'b1;
                  nxt_state     = (remaining == 1) ? st_idle : st_payload;
               end
            end
         end
         default: nxt_state = st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= st_idle;
         remaining <= '0;
      end else begin
         state     <= nxt_state;
         remaining <= nxt_remaining;
      end
   end

endmodule

`default_nettype wire

// File: source/mp_fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

// Register-0 traffic between bus decoder and the two controllers
interface mp_fifo_if;
   import mp_bus_pkg::*;

   // Read side, served by the ingress controller
   logic  rd_en;
   logic  rd_ack;
   word_t rd_data;

   // Write side, served by the egress controller
   logic  wr_en;
   logic  wr_ack;
   word_t wr_data;

   modport decoder (
      output rd_en, wr_en, wr_data,
      input  rd_ack, rd_data, wr_ack
   );

   modport ingress (
      input  rd_en,
      output rd_ack, rd_data
   );

   modport egress (
      input  wr_en, wr_data,
      output wr_ack
   );

endinterface

`default_nettype wire

// File: source/mp_ingress_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mp_ingress_ctrl (
   input  wire                 clk,
   input  wire                 rst,
   input  mp_noc_pkg::flit_t   buf_flit,
   input  wire                 buf_valid,
   input  mp_noc_pkg::size_t   buf_size,
   output logic                buf_ready,
   mp_fifo_if.ingress          fifo
);
   import mp_noc_pkg::*;
   import mp_bus_pkg::*;

   typedef enum logic {
      st_idle,
      st_flit
   } state_t;

   state_t state;
   state_t nxt_state;
   data_t  head_data;

   // Payload bits of the head flit, type dropped
   assign head_data = buf_flit[$bits(data_t)-1:0];

   always_comb begin
      nxt_state    = state;
      buf_ready    = 1'b0;
      fifo.rd_ack  = 1'b0;
      fifo.rd_data = '0;
      case (state)
         st_idle: begin
            // Size read, reads as 0 with nothing waiting
            if (fifo.rd_en) begin
               fifo.rd_ack = 1'b1;
               if (buf_valid) begin
                  fifo.rd_data = word_t'(buf_size);
                  if (buf_size != 0) begin
                     nxt_state = st_flit;
                  end
               end
            end
         end
         st_flit: begin
            // One word per read, popped as it is returned
            if (fifo.rd_en) begin
               fifo.rd_ack  = 1'b1;
               fifo.rd_data = word_t'(head_data);
               buf_ready    = 1'b1;
               if (buf_size == 1) begin
                  nxt_state = st_idle;
               end
            end
         end
         default: nxt_state = st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         state <= nxt_state;
      end
   end

endmodule

`default_nettype wire

// File: source/mp_noc_pkg.sv
`default_nettype none

`include "mp_settings.svh"

package mp_noc_pkg;

   typedef logic [`MP_DATA_WIDTH-1:0]                data_t;
   typedef logic [`MP_TYPE_WIDTH-1:0]                flit_type_t;
   typedef logic [`MP_TYPE_WIDTH+`MP_DATA_WIDTH-1:0] flit_t;
   typedef logic [4:0]                               node_t;
   typedef logic [2:0]                               class_t;
   // Holds 0 up to a full buffer
   typedef logic [$clog2(`MP_FIFO_DEPTH+1)-1:0]      size_t;

   localparam flit_type_t flit_payload = 2'b00;
   localparam flit_type_t flit_header  = 2'b01;
   localparam flit_type_t flit_last    = 2'b10;
   localparam flit_type_t flit_single  = 2'b11;

   // Field positions inside a flit
   localparam int type_lsb     = `MP_DATA_WIDTH;
   // Set for last and single, so it marks the end of a packet
   localparam int type_end_bit = type_lsb + 1;
   localparam int dest_lsb     = 27;
   localparam int class_lsb    = 24;
   localparam int src_lsb      = 19;

endpackage

`default_nettype wire

// File: source/mp_packet_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module mp_packet_buffer #(
   parameter int depth = 16
) (
   input  wire                 clk,
   input  wire                 rst,
   input  mp_noc_pkg::flit_t   in_flit,
   input  wire                 in_valid,
   input  wire                 out_ready,
   output logic                in_ready,
   output mp_noc_pkg::flit_t   out_flit,
   output logic                out_valid,
   output mp_noc_pkg::size_t   out_size
);
   import mp_noc_pkg::*;

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   typedef logic [ptr_w-1:0] ptr_t;
   typedef logic [cnt_w-1:0] cnt_t;

   // Flit store and queue of complete packet lengths
   flit_t mem [depth];
   size_t len_q [depth];

   ptr_t  wr_ptr;
   ptr_t  rd_ptr;
   ptr_t  len_wr;
   ptr_t  len_rd;
   cnt_t  flit_cnt;
   // Complete packets held
   cnt_t  pkt_cnt;
   // Flits so far of the packet being written
   size_t in_len;
   // Down-counter once the head packet is partly read
   size_t head_left;
   logic  head_loaded;
   logic  push;
   logic  push_end;
   logic  pop;
   logic  pop_end;

   function automatic ptr_t next_ptr(input ptr_t p);
      return (p == ptr_t'(depth - 1)) ? '0 : p + 1'b1;
   endfunction

   assign in_ready  = (flit_cnt != cnt_t'(depth));
   assign push      = in_valid & in_ready;
   assign push_end  = push & in_flit[type_end_bit];

   // Only whole packets are offered
   assign out_valid = (pkt_cnt != '0);
   assign out_flit  = mem[rd_ptr];
   assign out_size  = head_loaded ? head_left : len_q[len_rd];
   assign pop       = out_valid & out_ready;
   assign pop_end   = pop & (out_size == 1);

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_flit;
      end
      if (push_end) begin
         len_q[len_wr] <= in_len + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         len_wr      <= '0;
         len_rd      <= '0;
         flit_cnt    <= '0;
         pkt_cnt     <= '0;
         in_len      <= '0;
         head_left   <= '0;
         head_loaded <= 1'b0;
      end else begin
         flit_cnt <= flit_cnt + cnt_t'(push) - cnt_t'(pop);
         pkt_cnt  <= pkt_cnt + cnt_t'(push_end) - cnt_t'(pop_end);
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
            in_len <= push_end ? '0 : in_len + 1'b1;
         end
         if (push_end) begin
            len_wr <= next_ptr(len_wr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
            if (pop_end) begin
               // Next packet takes its length from the queue
               head_loaded <= 1'b0;
               len_rd      <= next_ptr(len_rd);
            end else begin
               head_loaded <= 1'b1;
               head_left   <= out_size - 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: source/mp_settings.svh
`ifndef MP_SETTINGS_SVH
`define MP_SETTINGS_SVH

// Flit payload width
`define MP_DATA_WIDTH 32

// Flit type field in the top bits of a flit
`define MP_TYPE_WIDTH 2

// Packet buffer depth in flits, for both directions
`define MP_FIFO_DEPTH 16

// Byte address on the register bus
`define MP_BUS_ADDR_WIDTH 6

// Packet class of a control message
`define MP_CTRL_CLASS 3'b111

// Register indices, taken from bus address bits 5 to 2
`define MP_REG_FIFO 4'd0
`define MP_REG_CTRL 4'd1

`endif

// File: source/mp_simple.sv
`timescale 1ns/1ps
`default_nettype none

`include "mp_settings.svh"

module mp_simple (
   input  wire                 clk,
   input  wire                 rst,
   input  mp_noc_pkg::flit_t   noc_in_flit,
   input  wire                 noc_in_valid,
   input  wire                 noc_out_ready,
   input  mp_bus_pkg::addr_t   bus_addr,
   input  wire                 bus_we,
   input  wire                 bus_en,
   input  mp_bus_pkg::word_t   bus_data_in,
   output mp_noc_pkg::flit_t   noc_out_flit,
   output logic                noc_out_valid,
   output logic                noc_in_ready,
   output mp_bus_pkg::word_t   bus_data_out,
   output logic                bus_ack,
   output logic                irq
);
   import mp_noc_pkg::*;

   logic  enabled;

   // Egress controller into egress buffer
   flit_t egr_in_flit;
   logic  egr_in_valid;
   logic  egr_in_ready;

   // Egress buffer into responder
   flit_t egr_flit;
   logic  egr_valid;
   logic  egr_ready;

   // Responder into ingress buffer
   flit_t ing_flit;
   logic  ing_valid;
   logic  ing_ready;

   // Ingress buffer into ingress controller
   flit_t in_flit;
   logic  in_valid;
   logic  in_ready;
   size_t in_size;

   mp_fifo_if fifo ();

   // Interrupt while a whole packet waits
   assign irq = in_valid;

   mp_bus_decode u_decode (
      .clk           (clk),
      .rst           (rst),
      .bus_addr      (bus_addr),
      .bus_we        (bus_we),
      .bus_en        (bus_en),
      .bus_data_in   (bus_data_in),
      .noc_out_valid (noc_out_valid),
      .irq           (irq),
      .bus_data_out  (bus_data_out),
      .bus_ack       (bus_ack),
      .enabled       (enabled),
      .fifo          (fifo.decoder)
   );

   mp_egress_ctrl u_egress_ctrl (
      .clk       (clk),
      .rst       (rst),
      .buf_ready (egr_in_ready),
      .buf_flit  (egr_in_flit),
      .buf_valid (egr_in_valid),
      .fifo      (fifo.egress)
   );

   mp_ingress_ctrl u_ingress_ctrl (
      .clk       (clk),
      .rst       (rst),
      .buf_flit  (in_flit),
      .buf_valid (in_valid),
      .buf_size  (in_size),
      .buf_ready (in_ready),
      .fifo      (fifo.ingress)
   );

   // Egress length not needed downstream
   mp_packet_buffer #(.depth(`MP_FIFO_DEPTH)) u_egress_buf (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (egr_in_flit),
      .in_valid  (egr_in_valid),
      .out_ready (egr_ready),
      .in_ready  (egr_in_ready),
      .out_flit  (egr_flit),
      .out_valid (egr_valid),
      .out_size  ()
   );

   mp_packet_buffer #(.depth(`MP_FIFO_DEPTH)) u_ingress_buf (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (ing_flit),
      .in_valid  (ing_valid),
      .out_ready (in_ready),
      .in_ready  (ing_ready),
      .out_flit  (in_flit),
      .out_valid (in_valid),
      .out_size  (in_size)
   );

   mp_control_responder u_responder (
      .clk           (clk),
      .rst           (rst),
      .enabled       (enabled),
      .noc_in_flit   (noc_in_flit),
      .noc_in_valid  (noc_in_valid),
      .ing_ready     (ing_ready),
      .egr_flit      (egr_flit),
      .egr_valid     (egr_valid),
      .noc_out_ready (noc_out_ready),
      .noc_in_ready  (noc_in_ready),
      .ing_flit      (ing_flit),
      .ing_valid     (ing_valid),
      .noc_out_flit  (noc_out_flit),
      .noc_out_valid (noc_out_valid),
      .egr_ready     (egr_ready)
   );

endmodule

`default_nettype wire

// File: verif/mp_simple_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mp_settings.svh"

module mp_simple_tb;
   import mp_noc_pkg::*;
   import mp_bus_pkg::*;

   localparam int bus_limit  = 200;
   localparam int wait_limit = 2000;
   localparam addr_t fifo_addr = addr_t'({`MP_REG_FIFO, 2'b00});
   localparam addr_t ctrl_addr = addr_t'({`MP_REG_CTRL, 2'b00});

   logic  clk;
   logic  rst;
   flit_t noc_in_flit;
   logic  noc_in_valid;
   logic  noc_out_ready;
   addr_t bus_addr;
   logic  bus_we;
   logic  bus_en;
   word_t bus_data_in;
   flit_t noc_out_flit;
   logic  noc_out_valid;
   logic  noc_in_ready;
   word_t bus_data_out;
   logic  bus_ack;
   logic  irq;

   // Random NoC output stalls when set
   logic  backpressure;
   // Flits seen on the NoC output and the ones still expected
   flit_t out_q [$];
   flit_t exp_q [$];
   word_t pkt_data [`MP_FIFO_DEPTH];
   string cur_test;
   int    errors;
   int    test_start_errors;
   int    tests_run;
   int    tests_ok;

   mp_simple DUT (
      .clk           (clk),
      .rst           (rst),
      .noc_in_flit   (noc_in_flit),
      .noc_in_valid  (noc_in_valid),
      .noc_out_ready (noc_out_ready),
      .bus_addr      (bus_addr),
      .bus_we        (bus_we),
      .bus_en        (bus_en),
      .bus_data_in   (bus_data_in),
      .noc_out_flit  (noc_out_flit),
      .noc_out_valid (noc_out_valid),
      .noc_in_ready  (noc_in_ready),
      .bus_data_out  (bus_data_out),
      .bus_ack       (bus_ack),
      .irq           (irq)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Output ready with random stalls while backpressure is on
   initial begin : ready_drive
      noc_out_ready = 1'b1;
      forever begin
         @(posedge clk);
         #5;
         noc_out_ready = backpressure ? ($urandom_range(3, 0) != 0) : 1'b1;
      end
   end

   // Flits that move on the NoC output are sampled mid-cycle
   initial begin : monitor
      forever begin
         @(negedge clk);
         if (!rst && noc_out_valid && noc_out_ready) begin
            out_q.push_back(noc_out_flit);
         end
      end
   end

   // In-order match of output flits against expected ones
   initial begin : compare
      flit_t got;
      flit_t want;
      forever begin
         @(posedge clk);
         while (out_q.size() > 0) begin
            got = out_q.pop_front();
            if (exp_q.size() == 0) begin
               $display("[ERROR] %0s: unexpected flit %h on the NoC output", cur_test, got);
               errors++;
            end else begin
               want = exp_q.pop_front();
               check_flit("noc_out flit", want, got);
            end
         end
      end
   end

   // Flit type follows the position in the packet
   function automatic flit_t expected_flit(input int i, input int n, input data_t d);
      flit_type_t t;
      if (n == 1) begin
         t = 2'b11;
      end else if (i == 0) begin
         t = 2'b01;
      end else if (i == n - 1) begin
         t = 2'b10;
      end else begin
         t = 2'b00;
      end
      return {t, d};
   endfunction

   // Swapped nodes, control class, enable in bit 1, bit 0 set
   function automatic flit_t expected_reply(input flit_t req, input logic en);
      return {2'b11, req[23:19], `MP_CTRL_CLASS, req[31:27], 17'd0, en, 1'b1};
   endfunction

   // Random nodes and filler bits around the request fields
   function automatic flit_t make_request();
      flit_t f;
      f = {2'b11, data_t'($urandom())};
      f[26:24] = `MP_CTRL_CLASS;
      f[0] = 1'b0;
      return f;
   endfunction

   task automatic check_word(input string what, input word_t want, input word_t got);
      if (got !== want) begin
         $display("[FAIL] %0s %0s: expected %h, actual %h", cur_test, what, want, got);
         errors++;
      end
   endtask

   task automatic check_flit(input string what, input flit_t want, input flit_t got);
      if (got !== want) begin
         $display("[FAIL] %0s %0s: expected %h, actual %h", cur_test, what, want, got);
         errors++;
      end
   endtask

   task automatic check_bit(input string what, input logic want, input logic got);
      if (got !== want) begin
         $display("[FAIL] %0s %0s: expected %b, actual %b", cur_test, what, want, got);
         errors++;
      end
   endtask

   task automatic step();
      @(posedge clk);
      #5;
   endtask

   // Held until bus_ack is seen at the falling edge
   task automatic bus_access(input logic we, input addr_t addr, input word_t wdata,
                             output word_t rdata, output logic ok);
      int waited;
      waited      = 0;
      ok          = 1'b0;
      rdata       = '0;
      bus_en      = 1'b1;
      bus_we      = we;
      bus_addr    = addr;
      bus_data_in = wdata;
      while (!ok && waited < bus_limit) begin
         @(negedge clk);
         if (bus_ack) begin
            ok    = 1'b1;
            rdata = bus_data_out;
         end
         waited++;
         step();
      end
      bus_en = 1'b0;
      bus_we = 1'b0;
      if (!ok) begin
         $display("[ERROR] %0s: bus access to address %h got no ack in %0d cycles",
                  cur_test, addr, bus_limit);
         errors++;
      end
   endtask

   task automatic send_flit(input flit_t f);
      int   waited;
      logic taken;
      waited       = 0;
      taken        = 1'b0;
      noc_in_flit  = f;
      noc_in_valid = 1'b1;
      while (!taken && waited < bus_limit) begin
         @(negedge clk);
         taken = noc_in_ready;
         waited++;
         step();
      end
      noc_in_valid = 1'b0;
      if (!taken) begin
         $display("[ERROR] %0s: NoC input never ready for flit %h", cur_test, f);
         errors++;
      end
   endtask

   // Size write, then one bus write per flit
   task automatic send_egress(input int n);
      word_t rdata;
      logic  ok;
      for (int i = 0; i < n; i++) begin
         pkt_data[i] = $urandom();
         exp_q.push_back(expected_flit(i, n, pkt_data[i]));
      end
      bus_access(1'b1, fifo_addr, word_t'(n), rdata, ok);
      for (int i = 0; i < n; i++) begin
         bus_access(1'b1, fifo_addr, pkt_data[i], rdata, ok);
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while ((exp_q.size() != 0 || out_q.size() != 0) && waited < wait_limit) begin
         step();
         waited++;
      end
      if (exp_q.size() != 0) begin
         $display("[ERROR] %0s: %0d expected flits never left the NoC output",
                  cur_test, exp_q.size());
         exp_q.delete();
         errors++;
      end
   endtask

   task automatic wait_irq();
      int   waited;
      logic seen;
      waited = 0;
      seen   = 1'b0;
      while (!seen && waited < wait_limit) begin
         @(negedge clk);
         seen = irq;
         waited++;
      end
      step();
      if (!seen) begin
         $display("[ERROR] %0s: irq did not rise in %0d cycles", cur_test, wait_limit);
         errors++;
      end
   endtask

   task automatic begin_test(input string name);
      cur_test          = name;
      test_start_errors = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors == test_start_errors) begin
         tests_ok++;
         $display("test %0s: ok", cur_test);
      end else begin
         $display("test %0s: %0d errors", cur_test, errors - test_start_errors);
      end
   endtask

   initial begin : main
      word_t rdata;
      logic  ok;
      flit_t req;
      int    n;
      rst          = 1'b1;
      bus_en       = 1'b0;
      bus_we       = 1'b0;
      bus_addr     = '0;
      bus_data_in  = '0;
      noc_in_flit  = '0;
      noc_in_valid = 1'b0;
      backpressure = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_ok     = 0;
      cur_test     = "reset";
      void'($urandom(31263));
      repeat (4) @(posedge clk);
      #5;
      rst = 1'b0;

      // Quiet outputs and empty reads
      begin_test("after_reset");
      @(negedge clk);
      check_bit("noc_out_valid", 1'b0, noc_out_valid);
      check_bit("irq", 1'b0, irq);
      step();
      bus_access(1'b0, ctrl_addr, '0, rdata, ok);
      check_word("status", '0, rdata);
      bus_access(1'b0, fifo_addr, '0, rdata, ok);
      check_bit("fifo read ack", 1'b1, ok);
      check_word("empty fifo read", '0, rdata);
      end_test();

      // Sizes 1, 2 and one random size under output stalls
      begin_test("egress_packets");
      backpressure = 1'b1;
      send_egress(1);
      send_egress(2);
      send_egress($urandom_range(`MP_FIFO_DEPTH, 3));
      wait_drain();
      end_test();

      begin_test("ingress_packet");
      n = $urandom_range(`MP_FIFO_DEPTH, 1);
      for (int i = 0; i < n; i++) begin
         pkt_data[i] = $urandom();
      end
      // Class 0 so a single flit is never a control request
      pkt_data[0][26:24] = 3'b000;
      for (int i = 0; i < n; i++) begin
         send_flit(expected_flit(i, n, pkt_data[i]));
      end
      wait_irq();
      bus_access(1'b0, fifo_addr, '0, rdata, ok);
      check_word("size", word_t'(n), rdata);
      for (int i = 0; i < n; i++) begin
         bus_access(1'b0, fifo_addr, '0, rdata, ok);
         check_word("data", pkt_data[i], rdata);
      end
      @(negedge clk);
      check_bit("irq after read", 1'b0, irq);
      step();
      end_test();

      // Reply before and after the enable write
      begin_test("control_requests");
      req = make_request();
      exp_q.push_back(expected_reply(req, 1'b0));
      send_flit(req);
      // First cycle after capture holds the input and offers the reply
      @(negedge clk);
      check_bit("noc_in_ready while reply pending", 1'b0, noc_in_ready);
      check_bit("noc_out_valid with reply pending", 1'b1, noc_out_valid);
      step();
      wait_drain();
      bus_access(1'b0, ctrl_addr, '0, rdata, ok);
      check_word("status before enable", '0, rdata);
      bus_access(1'b1, ctrl_addr, 32'd1, rdata, ok);
      req = make_request();
      exp_q.push_back(expected_reply(req, 1'b1));
      send_flit(req);
      wait_drain();
      bus_access(1'b0, ctrl_addr, '0, rdata, ok);
      check_word("status after enable", '0, rdata);
      // Requests never reach the ingress buffer
      bus_access(1'b0, fifo_addr, '0, rdata, ok);
      check_word("ingress after requests", '0, rdata);
      @(negedge clk);
      check_bit("irq", 1'b0, irq);
      step();
      end_test();

      // Full-depth packet is whole in the buffer before it drains
      begin_test("reply_between_packets");
      send_egress(`MP_FIFO_DEPTH);
      req = make_request();
      // Reply expected only after the packet's last flit
      exp_q.push_back(expected_reply(req, 1'b1));
      send_flit(req);
      wait_drain();
      end_test();

      backpressure = 1'b0;
      repeat (4) step();
      $display("tests run %0d, ok %0d, errors %0d", tests_run, tests_ok, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
